// ==== flist.f ====
src/g729FramePkg.sv
src/g729StepPkg.sv
src/frameTracker.sv
src/encoderSequencer.sv
src/stepDispatch.sv
src/g729EncoderControl.sv
verification/unitResponder.sv
verification/encoderControlTb.sv

// ==== verification/encoderControlTb.sv ====
`default_nettype none

module encoderControlTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int Seed = 12;
	localparam int NumEncodes = 20;
	localparam int MaxSteps = 32;                   // 13 frame steps, 10 and 9 in the subframes
	localparam int TimeoutCycles = NumEncodes * (MaxSteps * 10 + 280);

	// Unit of every step, frame part first, then one pass of the subframe loop
	localparam g729StepPkg::unitId ProgramUnits [23] = '{
		g729StepPkg::Autocorr, g729StepPkg::LagWindow, g729StepPkg::Levinson,
		g729StepPkg::AzToLsp, g729StepPkg::QuaLsp, g729StepPkg::IntLpc,
		g729StepPkg::IntQlpc, g729StepPkg::PercVar, g729StepPkg::WeightAz,
		g729StepPkg::WeightAz, g729StepPkg::Residu, g729StepPkg::SynFilt,
		g729StepPkg::PitchOl,
		g729StepPkg::WeightAz, g729StepPkg::WeightAz, g729StepPkg::SynFilt,
		g729StepPkg::Residu, g729StepPkg::PitchFr3, g729StepPkg::EncLag3,
		g729StepPkg::ParityPitch, g729StepPkg::PredLt3, g729StepPkg::Convolve,
		g729StepPkg::GPitch
	};

	logic clock;
	logic reset;
	logic start;
	logic frameDone;
	logic divErr;
	logic strayEnable;
	g729StepPkg::unitVector unitDone;
	g729StepPkg::unitVector unitStart;
	g729StepPkg::mathSelect muxSelect;
	logic encodeDone;

	integer seed;
	int cycleCount;
	int encode;
	int expUnit [$];                                // Expected start order
	int expCode [$];

	g729EncoderControl dut (
		.clock(clock),
		.reset(reset),
		.start(start),
		.frameDone(frameDone),
		.divErr(divErr),
		.unitDone(unitDone),
		.unitStart(unitStart),
		.muxSelect(muxSelect),
		.encodeDone(encodeDone)
	);

	unitResponder #(
		.Seed(Seed)
	) responder (
		.clock(clock),
		.reset(reset),
		.strayEnable(strayEnable),
		.unitStart(unitStart),
		.unitDone(unitDone)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#20 clock = ~clock;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("TB FAILED");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic checkValue(input string testName, input int expected, input int actual);
		assert (actual == expected)
		else
			reportFailure($sformatf("CHECK FAILED %s expected %0h actual %0h",
				testName, expected, actual));
	endtask

	task automatic nextDriveSlot();
		@(posedge clock);
		#2;                                         // Inputs change just after the edge
	endtask

	task automatic pulseFrame();
		nextDriveSlot();
		frameDone = 1'b1;
		nextDriveSlot();
		frameDone = 1'b0;
	endtask

	task automatic checkQuiet(input string testName, input int cycles);
		repeat (cycles)
		begin
			@(negedge clock);
			assert (unitStart == '0 && !encodeDone)
			else
				reportFailure({testName, ": unit start or encode done while nothing should run"});
			checkValue({testName, " idle muxSelect"}, 0, muxSelect);
		end
	endtask

	// Expected (unit, code) pairs with parity pitch only in the first subframe
	task automatic buildProgram();
		int step;
		int sub;
		expUnit.delete();
		expCode.delete();
		for (step = 0; step < 13; step++)
		begin
			expUnit.push_back(int'(ProgramUnits[step]));
			expCode.push_back(step + 1);
		end
		for (sub = 0; sub < g729FramePkg::FrameLength / g729FramePkg::SubframeLength; sub++)
			for (step = 13; step < 23; step++)
				if (ProgramUnits[step] != g729StepPkg::ParityPitch || sub == 0)
				begin
					expUnit.push_back(int'(ProgramUnits[step]));
					expCode.push_back(step + 1);
				end
	endtask

	task automatic armEncoder(input string testName, input logic stray);
		int gap;
		nextDriveSlot();
		start = 1'b1;
		strayEnable = stray;
		nextDriveSlot();
		start = 1'b0;
		gap = 1 + $unsigned($random(seed)) % 6;
		checkQuiet({testName, " before frames"}, gap);
		pulseFrame();
		checkQuiet({testName, " between frames"}, gap);
		pulseFrame();
	endtask

	// Follows one encode step by step and raises divErr at step abortAt
	task automatic followEncode(input string testName, input int abortAt);
		int unit;
		int index;
		int parityCount;
		int weightCount;
		buildProgram();
		parityCount = 0;
		weightCount = 0;
		@(negedge clock);
		while (unitStart == '0)
			@(negedge clock);
		for (index = 0; index < expUnit.size(); index++)
		begin
			unit = expUnit[index];
			checkValue($sformatf("%s step %0d start", testName, index), 1 << unit, unitStart);
			checkValue($sformatf("%s step %0d code", testName, index), expCode[index], muxSelect);
			if (unitStart[g729StepPkg::ParityPitch])
				parityCount++;
			if (unitStart[g729StepPkg::WeightAz])
				weightCount++;
			if (index == abortAt)
			begin
				nextDriveSlot();
				divErr = 1'b1;
				nextDriveSlot();
				divErr = 1'b0;
				checkQuiet({testName, " after divErr"}, 20);
				return;
			end
			do
			begin
				@(negedge clock);
				checkValue({testName, " busy code"}, expCode[index], muxSelect);
				assert (unitStart == '0 && !encodeDone)
				else
					reportFailure({testName, ": extra unit start or early encode done"});
			end
			while (!unitDone[unit]);
			@(negedge clock);
		end
		assert (encodeDone)
		else
			reportFailure({testName, ": no encode done after the final step"});
		checkValue({testName, " parity count"}, 1, parityCount);
		checkValue({testName, " weighting count"}, 6, weightCount);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		cycleCount = 0;
		while (cycleCount < TimeoutCycles)
		begin
			@(posedge clock);
			cycleCount++;
		end
		reportFailure($sformatf("Timeout, the run did not end within %0d cycles", TimeoutCycles));
	end

	initial
	begin
		seed = Seed;
		reset = 1'b1;
		start = 1'b0;
		frameDone = 1'b0;
		divErr = 1'b0;
		strayEnable = 1'b0;
		repeat (5)
			@(posedge clock);
		#2;
		reset = 1'b0;
		checkQuiet("reset idle", 20);
		for (encode = 0; encode < NumEncodes; encode++)
		begin
			if (encode % 4 == 3)
			begin
				armEncoder($sformatf("abort %0d", encode), 1'b1);
				followEncode($sformatf("abort %0d", encode), $unsigned($random(seed)) % MaxSteps);
			end
			armEncoder($sformatf("encode %0d", encode), encode % 2 == 1);
			followEncode($sformatf("encode %0d", encode), -1);
			checkQuiet($sformatf("encode %0d done", encode), 10);
			// Frame pair with no start strobe gives a lost analysis strobe
			pulseFrame();
			pulseFrame();
			checkQuiet($sformatf("encode %0d lone frames", encode), 10);
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/unitResponder.sv ====
`default_nettype none

module unitResponder #(
	parameter int Seed = 12
) (
	input logic clock,
	input logic reset,
	input logic strayEnable,
	input g729StepPkg::unitVector unitStart,
	output g729StepPkg::unitVector unitDone
);

	timeunit 1ns;
	timeprecision 1ps;

	integer seed;
	int remaining [g729StepPkg::NumUnits];      // Cycles until done, 0 when the unit is idle
	int unit;
	int stray;
	logic inReset;
	logic strayOn;

	initial
	begin
		seed = Seed;
		unitDone = '0;
		for (unit = 0; unit < g729StepPkg::NumUnits; unit++)
			remaining[unit] = 0;
	end

	// Levels driven by the testbench are taken at the edge, the DUT's starts just after it
	always @(posedge clock)
	begin
		inReset = reset;
		strayOn = strayEnable;
		#2;
		unitDone = '0;
		for (unit = 0; unit < g729StepPkg::NumUnits; unit++)
		begin
			if (inReset)
				remaining[unit] = 0;
			else
			begin
				if (remaining[unit] == 1)
					unitDone[unit] = 1'b1;      // Busy time is over
				if (remaining[unit] > 0)
					remaining[unit]--;
				if (unitStart[unit])
					remaining[unit] = 1 + $unsigned($random(seed)) % 8;
			end
		end
		// Occasional done strobe from a unit that is not working
		if (!inReset && strayOn && ($unsigned($random(seed)) % 4 == 0))
		begin
			stray = $unsigned($random(seed)) % g729StepPkg::NumUnits;
			if (remaining[stray] == 0)
				unitDone[stray] = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/g729EncoderControl.sv ====
`default_nettype none

module g729EncoderControl #(
	parameter int FramesPerAnalysis = 2,
	parameter int FrameLength = g729FramePkg::FrameLength,
	parameter int SubframeLength = g729FramePkg::SubframeLength
) (
	input logic clock,
	input logic reset,
	input logic start,
	input logic frameDone,
	input logic divErr,
	input g729StepPkg::unitVector unitDone,
	output g729StepPkg::unitVector unitStart,
	output g729StepPkg::mathSelect muxSelect,
	output logic encodeDone
);

	logic analysisReady;
	g729StepPkg::stepIndex activeStep;
	logic stepActive;
	logic stepLaunch;
	logic stepDone;

	frameTracker #(
		.FramesPerAnalysis(FramesPerAnalysis)
	) tracker (
		.clock(clock),
		.reset(reset),
		.start(start),
		.frameDone(frameDone),
		.analysisReady(analysisReady)
	);

	encoderSequencer #(
		.FrameLength(FrameLength),
		.SubframeLength(SubframeLength)
	) sequencer (
		.clock(clock),
		.reset(reset),
		.start(start),
		.divErr(divErr),
		.analysisReady(analysisReady),
		.stepDone(stepDone),
		.activeStep(activeStep),
		.stepActive(stepActive),
		.stepLaunch(stepLaunch),
		.encodeDone(encodeDone)
	);

	stepDispatch dispatch (
		.activeStep(activeStep),
		.stepActive(stepActive),
		.stepLaunch(stepLaunch),
		.unitDone(unitDone),
		.unitStart(unitStart),
		.muxSelect(muxSelect),
		.stepDone(stepDone)
	);

endmodule

`default_nettype wire

// ==== src/stepDispatch.sv ====
`default_nettype none

module stepDispatch (
	input g729StepPkg::stepIndex activeStep,
	input logic stepActive,
	input logic stepLaunch,
	input g729StepPkg::unitVector unitDone,
	output g729StepPkg::unitVector unitStart,
	output g729StepPkg::mathSelect muxSelect,
	output logic stepDone
);

	g729StepPkg::unitId stepUnit;
	g729StepPkg::mathSelect stepCode;
	g729StepPkg::unitVector unitMask;           // One-hot of the active unit

	////////////////////////////////////////////////////////////
	// Program table lookup
	////////////////////////////////////////////////////////////

	always_comb
	begin
		stepUnit = g729StepPkg::StepUnit[activeStep];
		stepCode = g729StepPkg::StepCode[activeStep];
	end

	assign unitMask = g729StepPkg::unitVector'(1) << stepUnit;

	// Start strobe goes only to the unit of the launched step
	always_comb
	begin
		if (stepActive && stepLaunch)
			unitStart = unitMask;
		else
			unitStart = '0;
	end

	always_comb
	begin
		if (stepActive)
			muxSelect = stepCode;
		else
			muxSelect = '0;                     // Idle code
	end

	// Done strobes from every other unit are ignored
	assign stepDone = stepActive && ((unitDone & unitMask) != '0);

endmodule

`default_nettype wire

// ==== src/encoderSequencer.sv ====
`default_nettype none

module encoderSequencer #(
	parameter int FrameLength = 80,
	parameter int SubframeLength = 40
) (
	input logic clock,
	input logic reset,
	input logic start,
	input logic divErr,
	input logic analysisReady,
	input logic stepDone,
	output g729StepPkg::stepIndex activeStep,
	output logic stepActive,
	output logic stepLaunch,
	output logic encodeDone
);

	typedef enum logic [1:0] {
		Idle,
		WaitAnalysis,
		RunStep,
		Finish
	} sequencerState;

	sequencerState state;

	g729FramePkg::sampleIndex subframeStart;        // First sample of the current subframe
	g729FramePkg::sampleIndex nextSubframe;
	g729StepPkg::stepIndex stepAfter;
	g729StepPkg::stepIndex nextStep;
	logic skipParity;
	logic loopEnd;
	logic moreSubframes;

	////////////////////////////////////////////////////////////
	// Next step of the program
	////////////////////////////////////////////////////////////

	assign stepAfter = activeStep + 5'd1;

	// Parity of the pitch delay is only coded in the first subframe
	assign skipParity = (stepAfter == g729StepPkg::ParityStep) && (subframeStart != '0);

	assign nextStep = skipParity ? stepAfter + 5'd1 : stepAfter;

	assign loopEnd = activeStep == g729StepPkg::LastStep;

	assign nextSubframe = subframeStart + g729FramePkg::sampleIndex'(SubframeLength);
	assign moreSubframes = nextSubframe < g729FramePkg::sampleIndex'(FrameLength);

	////////////////////////////////////////////////////////////
	// Sequencer FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= Idle;
			activeStep <= '0;
			subframeStart <= '0;
			stepLaunch <= 1'b0;
		end
		else
		begin
			stepLaunch <= 1'b0;
			if (divErr)
				state <= Idle;                  // Abort without encodeDone
			else
			begin
				case (state)
					Idle:
					begin
						if (start)
						begin
							subframeStart <= '0;
							state <= WaitAnalysis;
						end
					end
					WaitAnalysis:
					begin
						if (analysisReady)
						begin
							activeStep <= '0;
							stepLaunch <= 1'b1;
							state <= RunStep;
						end
					end
					RunStep:
					begin
						if (stepDone)
						begin
							if (!loopEnd)
							begin
								activeStep <= nextStep;
								stepLaunch <= 1'b1;
							end
							else if (moreSubframes)
							begin
								// Back to the top of the subframe loop
								subframeStart <= nextSubframe;
								activeStep <= g729StepPkg::FirstLoopStep;
								stepLaunch <= 1'b1;
							end
							else
								state <= Finish;
						end
					end
					Finish:
						state <= Idle;
					default:
						state <= Idle;
				endcase
			end
		end
	end

	assign stepActive = state == RunStep;
	assign encodeDone = state == Finish;        // Lasts one cycle before Idle

	// A unit answers no earlier than the cycle after its start
	doneAfterLaunch: assert property (@(posedge clock) disable iff (reset)
		stepLaunch |-> !stepDone);

endmodule

`default_nettype wire

// ==== src/frameTracker.sv ====
`default_nettype none

module frameTracker #(
	parameter int FramesPerAnalysis = 2
) (
	input logic clock,
	input logic reset,
	input logic start,
	input logic frameDone,
	output logic analysisReady
);

	localparam int CountWidth = (FramesPerAnalysis > 1) ? $clog2(FramesPerAnalysis) : 1;

	typedef enum logic {
		Disarmed,
		Counting
	} trackerState;

	typedef logic [CountWidth-1:0] frameCounter;

	trackerState state;
	frameCounter frameCount;                    // Frames seen in the current group
	logic groupComplete;

	assign groupComplete = frameDone && (frameCount == frameCounter'(FramesPerAnalysis - 1));

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= Disarmed;
			frameCount <= '0;
			analysisReady <= 1'b0;
		end
		else
		begin
			analysisReady <= 1'b0;              // Strobe by default
			case (state)
				Disarmed:
				begin
					if (start)
					begin
						state <= Counting;
						frameCount <= '0;
					end
				end
				Counting:
				begin
					// Stays armed, every group of frames gives one strobe
					if (groupComplete)
					begin
						frameCount <= '0;
						analysisReady <= 1'b1;
					end
					else if (frameDone)
						frameCount <= frameCount + 1'b1;
				end
				default:
					state <= Disarmed;
			endcase
		end
	end

	readyIsStrobe: assert property (@(posedge clock) disable iff (reset)
		analysisReady |=> !analysisReady);

endmodule

`default_nettype wire

// ==== src/g729StepPkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////
// Processing units and the encoder step program
////////////////////////////////////////////////////////////

package g729StepPkg;

	// External processing units, one start and one done line each
	typedef enum logic [4:0] {
		Autocorr,
		LagWindow,
		Levinson,
		AzToLsp,
		QuaLsp,
		IntLpc,
		IntQlpc,
		PercVar,
		WeightAz,
		Residu,
		SynFilt,
		PitchOl,
		PitchFr3,
		EncLag3,
		ParityPitch,
		PredLt3,
		Convolve,
		GPitch
	} unitId;

	localparam int NumUnits = int'(GPitch) + 1;    // Last enum entry sets the count

	typedef logic [NumUnits-1:0] unitVector;       // One bit per unit, indexed by unitId
	typedef logic [5:0] mathSelect;                // Math unit mux code, 0 is idle
	typedef logic [4:0] stepIndex;                 // Position in the step program

	localparam int NumSteps = 23;

	localparam stepIndex FirstLoopStep = 5'd13;    // Start of the subframe loop
	localparam stepIndex ParityStep = 5'd19;       // First subframe only
	localparam stepIndex LastStep = 5'd22;

	////////////////////////////////////////////////////////////
	// Step program
	////////////////////////////////////////////////////////////

	// Steps 0 to 12 run once per frame, 13 to 22 once per subframe
	localparam unitId StepUnit [NumSteps] = '{
		Autocorr,
		LagWindow,
		Levinson,
		AzToLsp,
		QuaLsp,
		IntLpc,
		IntQlpc,
		PercVar,
		WeightAz,                                  // Weighting for gamma1
		WeightAz,                                  // Weighting for gamma2
		Residu,
		SynFilt,
		PitchOl,
		WeightAz,                                  // Subframe loop starts here
		WeightAz,
		SynFilt,
		Residu,
		PitchFr3,
		EncLag3,
		ParityPitch,
		PredLt3,
		Convolve,
		GPitch
	};

	// Mux code per step, code 0 left for idle
	localparam mathSelect StepCode [NumSteps] = '{
		6'd1,  6'd2,  6'd3,  6'd4,  6'd5,  6'd6,  6'd7,  6'd8,
		6'd9,  6'd10, 6'd11, 6'd12, 6'd13,
		6'd14, 6'd15, 6'd16, 6'd17, 6'd18, 6'd19, 6'd20,
		6'd21, 6'd22, 6'd23
	};

endpackage

`default_nettype wire

// ==== src/g729FramePkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////
// Frame geometry of the G.729 encoder
////////////////////////////////////////////////////////////

package g729FramePkg;

	// 10 ms of speech at 8 kHz
	localparam int FrameLength = 80;            // Samples per frame
	localparam int SubframeLength = 40;         // Samples per subframe

	localparam int SampleIndexWidth = 16;       // Matches the datapath address width

	// Start sample of a subframe inside the frame
	typedef logic [SampleIndexWidth-1:0] sampleIndex;

endpackage

`default_nettype wire
